/* hw/gb80_pkg.sv */
package gb80_pkg;

   // Basic data and address words
   typedef logic [7:0]  byte_t;
   typedef logic [15:0] addr_t;

   // Address split into page and offset bytes
   typedef struct packed {
      byte_t page;
      byte_t offset;
   } addr_parts_t;

   // One address word seen two ways
   // Raw word for range compares, page and offset for indexing
   typedef union packed {
      addr_t       raw;
      addr_parts_t part;
   } addr_u;

   // Number of interrupt sources
   localparam int IRQ_COUNT = 5;

   // One bit per interrupt source
   // Bit 0 vblank (highest priority)
   // Bit 1 lcdc
   // Bit 2 tima
   // Bit 3 serial
   // Bit 4 hilo (lowest priority)
   typedef logic [IRQ_COUNT-1:0] irq_bits_t;

   // High RAM window starts here
   localparam addr_t HRAM_BASE = 16'hFF80;

   // Default high RAM size in bytes
   // Fills FF80 up to FFFE
   localparam int HRAM_DEPTH_DEFAULT = 127;

   // Interrupt enable register address
   localparam addr_t MMIO_IE = 16'hFFFF;

   // Jump vector of source 0
   localparam byte_t IRQ_VECTOR_BASE = 8'h40;

   // Distance between consecutive vectors
   localparam byte_t IRQ_VECTOR_STRIDE = 8'h08;

   // Master enable state out of reset
   localparam logic IME_RESET_VALUE = 1'b1;

endpackage

/* hw/hram_port_if.sv */
interface hram_port_if import gb80_pkg::*; ();

   // Write strobe for one cycle
   logic  we;

   // Read strobe for one cycle
   logic  re;

   // Byte index into the RAM array
   logic [6:0] index;

   // Byte to store on we
   byte_t wdata;

   // Byte at index while re is high
   byte_t rdata;

   // Address decoder side
   modport decoder (
      output we, re, index, wdata,
      input  rdata
   );

   // RAM array side
   modport ram (
      input  we, re, index, wdata,
      output rdata
   );

endinterface

/* hw/high_ram.sv */
module high_ram import gb80_pkg::*; #(
   parameter int hram_depth = HRAM_DEPTH_DEFAULT
) (
   input  logic         clock,
   hram_port_if.ram     port
);

   // Storage array
   byte_t mem [hram_depth];

   // Index inside the array
   logic  index_ok;

   // Guard against indices past the last entry
   assign index_ok = int'(port.index) < hram_depth;

   // Synchronous write
   always_ff @(posedge clock) begin
      if (port.we && index_ok) begin
         mem[port.index] <= port.wdata;
      end
   end

   // Combinational read
   // Output held at zero when not selected
   always_comb begin
      if (port.re && index_ok) begin
         port.rdata = mem[port.index];
      end else begin
         port.rdata = '0;
      end
   end

endmodule

/* hw/mem_decoder.sv */
module mem_decoder import gb80_pkg::*; #(
   parameter int hram_depth = HRAM_DEPTH_DEFAULT
) (
   input  logic        clock,
   input  logic        reset,

   // CPU side
   input  addr_t       addr,
   input  byte_t       wdata,
   input  logic        wr,
   input  logic        rd,
   input  logic        mem_disable,

   // External memory bus
   output addr_t       addr_ext,
   inout  wire byte_t  data_ext,
   output logic        mem_we_n,
   output logic        mem_re_n,

   // Read buffer
   output byte_t       rdata,

   // Enable register access
   input  irq_bits_t   ie_data,
   output logic        ie_write,
   output irq_bits_t   ie_wdata,

   // High RAM port
   hram_port_if.decoder hram
);

   // Last byte address of the high RAM window
   localparam addr_t HRAM_LAST = addr_t'(HRAM_BASE + hram_depth - 1);

   // Address in both views
   addr_u a;

   // Region flags
   logic  is_ie;
   logic  in_hram;
   logic  is_ext;

   // Offset from the start of high RAM
   byte_t hram_off;

   // External bus strobes before inversion
   logic  ext_wr;
   logic  ext_rd;

   assign a.raw = addr;

   // Enable register takes FFFF even if RAM would reach it
   assign is_ie = a.raw == MMIO_IE;

   // High RAM range compare on the raw word
   assign in_hram = (a.raw >= HRAM_BASE) && (a.raw <= HRAM_LAST) && !is_ie;

   // Everything else goes outside
   assign is_ext = !in_hram && !is_ie;

   // RAM index from the low byte only
   assign hram_off = a.part.offset - HRAM_BASE[7:0];

   // High RAM port
   assign hram.we    = wr && in_hram;
   assign hram.re    = rd && in_hram;
   assign hram.index = hram_off[6:0];
   assign hram.wdata = wdata;

   // IE write pulse, low bits of the byte
   assign ie_write = wr && is_ie;
   assign ie_wdata = wdata[IRQ_COUNT-1:0];

   // External strobes, suppressed by mem_disable
   assign ext_wr = wr && is_ext && !mem_disable;
   assign ext_rd = rd && is_ext && !mem_disable;

   // Active low on the pins
   assign mem_we_n = !ext_wr;
   assign mem_re_n = !ext_rd;

   // Address always follows the CPU
   assign addr_ext = a.raw;

   // Drive data only during an external write
   assign data_ext = ext_wr ? wdata : 'z;

   // Read buffer
   // Loads on rd from the selected region, holds otherwise
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         rdata <= '0;
      end else if (rd) begin
         if (in_hram) begin
            rdata <= hram.rdata;
         end else if (is_ie) begin
            // Zero-extend the five enable bits
            rdata <= byte_t'(ie_data);
         end else if (mem_disable) begin
            rdata <= '0;
         end else begin
            rdata <= data_ext;
         end
      end
   end

endmodule

/* hw/interrupt_ctrl.sv */
module interrupt_ctrl import gb80_pkg::*; (
   input  logic      clock,
   input  logic      reset,

   // Flag register sources
   input  irq_bits_t if_set,
   input  logic      if_load,
   input  irq_bits_t if_in,

   // Enable register sources
   input  logic      ie_load,
   input  irq_bits_t ie_in,
   input  logic      ie_write,
   input  irq_bits_t ie_wdata,

   // Service and master enable control
   input  logic      irq_ack,
   input  logic      ime_set,
   input  logic      ime_reset,

   // Status
   output logic      irq,
   output byte_t     irq_vector,
   output irq_bits_t if_data,
   output irq_bits_t ie_data,
   output logic      ime
);

   // Flags that are both raised and enabled
   irq_bits_t pending;

   // Index of the winning source
   logic [2:0] sel;
   logic       found;

   // All ones except the serviced bit
   irq_bits_t clear_mask;

   // Flag register input after load and ack
   irq_bits_t if_base;

   assign pending = if_data & ie_data;

   // Fixed priority, lowest bit wins
   // Walk from the top so the lowest set bit is kept last
   always_comb begin
      sel   = '0;
      found = 1'b0;
      for (int i = IRQ_COUNT - 1; i >= 0; i--) begin
         if (pending[i]) begin
            sel   = 3'(i);
            found = 1'b1;
         end
      end
   end

   // Mask out only the selected source
   assign clear_mask = found ? ~(irq_bits_t'(1) << sel) : '1;

   // Vector is base plus stride per source, zero when idle
   assign irq_vector = found ? IRQ_VECTOR_BASE + IRQ_VECTOR_STRIDE * byte_t'(sel) : '0;

   // Request needs the master enable
   assign irq = ime && found;

   // Load first then clear on ack
   assign if_base = (if_load ? if_in : if_data) & (irq_ack ? clear_mask : '1);

   // Flag register
   // New requests ORed in last so they are never lost
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         if_data <= '0;
      end else begin
         if_data <= if_base | if_set;
      end
   end

   // Enable register
   // Memory write beats the direct load
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         ie_data <= '0;
      end else if (ie_write) begin
         ie_data <= ie_wdata;
      end else if (ie_load) begin
         ie_data <= ie_in;
      end
   end

   // Master enable, set beats reset
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         ime <= IME_RESET_VALUE;
      end else if (ime_set) begin
         ime <= 1'b1;
      end else if (ime_reset) begin
         ime <= 1'b0;
      end
   end

endmodule

/* hw/gb80_mem_irq.sv */
module gb80_mem_irq import gb80_pkg::*; #(
   parameter int hram_depth = HRAM_DEPTH_DEFAULT
) (
   input  logic       clock,
   input  logic       reset,

   // CPU memory access
   input  addr_t      addr,
   input  byte_t      wdata,
   input  logic       wr,
   input  logic       rd,
   input  logic       mem_disable,

   // External memory bus
   output addr_t      addr_ext,
   inout  wire byte_t data_ext,
   output logic       mem_we_n,
   output logic       mem_re_n,

   // Buffered read data
   output byte_t      rdata,

   // Interrupt inputs
   input  irq_bits_t  if_set,
   input  irq_bits_t  if_in,
   input  irq_bits_t  ie_in,
   input  logic       if_load,
   input  logic       ie_load,
   input  logic       irq_ack,
   input  logic       ime_set,
   input  logic       ime_reset,

   // Interrupt status
   output logic       irq,
   output byte_t      irq_vector,
   output irq_bits_t  if_data,
   output irq_bits_t  ie_data,
   output logic       ime
);

   // IE write path from memory
   logic      ie_write;
   irq_bits_t ie_wdata;

   // Decoder to RAM link
   hram_port_if hram_bus ();

   // Address steering, external bus and read buffer
   mem_decoder #(
      .hram_depth (hram_depth)
   ) u_mem_decoder (
      .clock       (clock),
      .reset       (reset),
      .addr        (addr),
      .wdata       (wdata),
      .wr          (wr),
      .rd          (rd),
      .mem_disable (mem_disable),
      .addr_ext    (addr_ext),
      .data_ext    (data_ext),
      .mem_we_n    (mem_we_n),
      .mem_re_n    (mem_re_n),
      .rdata       (rdata),
      .ie_data     (ie_data),
      .ie_write    (ie_write),
      .ie_wdata    (ie_wdata),
      .hram        (hram_bus.decoder)
   );

   // On-chip high RAM
   high_ram #(
      .hram_depth (hram_depth)
   ) u_high_ram (
      .clock (clock),
      .port  (hram_bus.ram)
   );

   // Flags, enables and priority select
   interrupt_ctrl u_interrupt_ctrl (
      .clock      (clock),
      .reset      (reset),
      .if_set     (if_set),
      .if_load    (if_load),
      .if_in      (if_in),
      .ie_load    (ie_load),
      .ie_in      (ie_in),
      .ie_write   (ie_write),
      .ie_wdata   (ie_wdata),
      .irq_ack    (irq_ack),
      .ime_set    (ime_set),
      .ime_reset  (ime_reset),
      .irq        (irq),
      .irq_vector (irq_vector),
      .if_data    (if_data),
      .ie_data    (ie_data),
      .ime        (ime)
   );

endmodule

/* tests/gb80_mem_irq_chk.sv */
module gb80_mem_irq_chk import gb80_pkg::*; (
   input logic      clock,
   input logic      reset,
   input logic      mem_we_n,
   input logic      mem_re_n,
   input logic      mem_disable,
   input logic      irq,
   input logic      ime,
   input logic      irq_ack,
   input logic      if_load,
   input irq_bits_t if_set,
   input irq_bits_t if_data,
   input irq_bits_t ie_data
);

   // Failed assertion count
   int assert_failures = 0;

   irq_bits_t pending;
   irq_bits_t low_bit;

   assign pending = if_data & ie_data;

   // Lowest pending bit only
   assign low_bit = pending & (~pending + 1'b1);

   // Strobes exclusive
   a_strobe_excl: assert property (@(posedge clock) disable iff (reset)
      !(!mem_we_n && !mem_re_n))
   else begin
      $error("mem_we_n and mem_re_n low together");
      assert_failures++;
   end

   // No bus cycle while memory is disabled
   a_disable: assert property (@(posedge clock) disable iff (reset)
      mem_disable |-> (mem_we_n && mem_re_n))
   else begin
      $error("Strobe low while mem_disable is high");
      assert_failures++;
   end

   a_irq_ime: assert property (@(posedge clock) disable iff (reset) irq |-> ime)
   else begin
      $error("irq high with ime low");
      assert_failures++;
   end

   // Serviced flag gone one edge after ack, unless reloaded or raised again
   a_ack_clear: assert property (@(posedge clock) disable iff (reset)
      (irq_ack && |pending && !if_load && !(|(if_set & low_bit)))
      |=> !(|(if_data & $past(low_bit))))
   else begin
      $error("Acknowledged flag not cleared");
      assert_failures++;
   end

endmodule

bind gb80_mem_irq gb80_mem_irq_chk u_chk (.*);

/* tests/tb_gb80_mem_irq.sv */
module tb_gb80_mem_irq import gb80_pkg::*; ();

   // Cycles per test in run order
   // Reset, high RAM, external, IE, priority and ime
   localparam int CYCLES_TOTAL = 4 + 12 + 18 + 4 + 6 + 3;

   logic       clock;
   logic       reset;
   addr_t      addr;
   byte_t      wdata;
   logic       wr;
   logic       rd;
   logic       mem_disable;
   addr_t      addr_ext;
   wire byte_t data_ext;
   logic       mem_we_n;
   logic       mem_re_n;
   byte_t      rdata;
   irq_bits_t  if_set;
   irq_bits_t  if_in;
   irq_bits_t  ie_in;
   logic       if_load;
   logic       ie_load;
   logic       irq_ack;
   logic       ime_set;
   logic       ime_reset;
   logic       irq;
   byte_t      irq_vector;
   irq_bits_t  if_data;
   irq_bits_t  ie_data;
   logic       ime;

   // External memory model of 64 bytes
   byte_t ext_mem [64];

   gb80_mem_irq #(.hram_depth(HRAM_DEPTH_DEFAULT)) UUT (.*);

   initial begin
      clock = 1'b0;
      forever #10 clock = ~clock;
   end

   // Model answers reads and takes writes on the strobe
   assign data_ext = !mem_re_n ? ext_mem[addr_ext[5:0]] : 'z;

   always @(posedge clock) begin
      if (reset) begin
         for (int i = 0; i < 64; i++) begin
            ext_mem[i] = byte_t'(i * 7 + 3);
         end
      end else if (!mem_we_n) begin
         ext_mem[addr_ext[5:0]] <= data_ext;
      end
   end

   initial begin
      #((CYCLES_TOTAL + 40) * 20);
      $display("Timeout: the tests did not finish within the cycle budget");
      $display(">>> FAIL");
      $fatal(1, "Watchdog expired");
   end

   // Next edge plus input delay
   task automatic step();
      @(posedge clock);
      #2;
   endtask

   task automatic report_mismatch(input string msg);
      $display("[FAIL] %0t: %s", $time, msg);
      $display(">>> FAIL");
      $fatal(1, "Stopped at first mismatch");
   endtask

   task automatic check_byte(input string what, input byte_t got, input byte_t exp);
      if (got !== exp) begin
         report_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
      end
   endtask

   task automatic check_addr(input string what, input addr_t got, input addr_t exp);
      if (got !== exp) begin
         report_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
      end
   endtask

   task automatic check_bits(input string what, input irq_bits_t got, input irq_bits_t exp);
      if (got !== exp) begin
         report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
      end
   endtask

   task automatic check_bit(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
      end
   endtask

   // Lowest set bit index or -1 when empty
   function automatic int lowest_index(input irq_bits_t b);
      for (int i = 0; i < IRQ_COUNT; i++) begin
         if (b[i]) begin
            return i;
         end
      end
      return -1;
   endfunction

   // One write cycle
   // ext set when the external bus should see it
   task automatic bus_write(input addr_t a, input byte_t d, input logic ext);
      step();
      addr = a;
      wdata = d;
      wr = 1'b1;
      #1;
      check_bit("mem_we_n", mem_we_n, !ext);
      check_bit("mem_re_n", mem_re_n, 1'b1);
      if (ext) begin
         check_addr("addr_ext", addr_ext, a);
         check_byte("data_ext", data_ext, d);
      end else begin
         check_byte("data_ext", data_ext, 'z);
      end
      step();
      wr = 1'b0;
   endtask

   // One read cycle
   // Buffer checked after the edge
   task automatic bus_read(input addr_t a, input logic ext, input byte_t exp);
      step();
      addr = a;
      rd = 1'b1;
      #1;
      check_bit("mem_re_n", mem_re_n, !ext);
      check_bit("mem_we_n", mem_we_n, 1'b1);
      if (ext) begin
         check_addr("addr_ext", addr_ext, a);
      end
      step();
      check_byte("rdata", rdata, exp);
      rd = 1'b0;
   endtask

   task automatic test_reset_state();
      check_bit("mem_we_n", mem_we_n, 1'b1);
      check_bit("mem_re_n", mem_re_n, 1'b1);
      check_byte("data_ext", data_ext, 'z);
      check_byte("rdata", rdata, 8'h00);
      check_bits("if_data", if_data, '0);
      check_bits("ie_data", ie_data, '0);
      check_bit("ime", ime, 1'b1);
      check_bit("irq", irq, 1'b0);
   endtask

   task automatic test_high_ram();
      addr_t hram_addr [3];
      byte_t data [3];
      hram_addr = '{16'hFF80, 16'hFFC0, 16'hFFFE};
      for (int i = 0; i < 3; i++) begin
         data[i] = byte_t'($urandom);
         bus_write(hram_addr[i], data[i], 1'b0);
      end
      for (int i = 0; i < 3; i++) begin
         bus_read(hram_addr[i], 1'b0, data[i]);
      end
   endtask

   task automatic test_external();
      addr_t ext_addr [3];
      byte_t data [3];
      ext_addr = '{16'h1234, 16'h8005, 16'hC03F};
      for (int i = 0; i < 3; i++) begin
         data[i] = byte_t'($urandom);
         bus_write(ext_addr[i], data[i], 1'b1);
      end
      for (int i = 0; i < 3; i++) begin
         bus_read(ext_addr[i], 1'b1, data[i]);
      end
      // Disabled bus drops the write and reads zero
      mem_disable = 1'b1;
      bus_write(ext_addr[0], ~data[0], 1'b0);
      bus_read(ext_addr[0], 1'b0, 8'h00);
      mem_disable = 1'b0;
      bus_read(ext_addr[0], 1'b1, data[0]);
   endtask

   task automatic test_ie_register();
      byte_t d;
      d = byte_t'($urandom);
      bus_write(MMIO_IE, d, 1'b0);
      check_bits("ie_data", ie_data, d[4:0]);
      bus_read(MMIO_IE, 1'b0, {3'b000, d[4:0]});
   endtask

   task automatic test_priority();
      irq_bits_t exp_if;
      irq_bits_t exp_ie;
      int        idx;
      exp_if = 5'b11110;
      exp_ie = 5'b10110;
      step();
      if_set = exp_if;
      ie_load = 1'b1;
      ie_in = exp_ie;
      step();
      if_set = '0;
      ie_load = 1'b0;
      check_bits("if_data", if_data, exp_if);
      check_bits("ie_data", ie_data, exp_ie);
      // Service pending sources in priority order
      while ((exp_if & exp_ie) != '0) begin
         idx = lowest_index(exp_if & exp_ie);
         check_bit("irq", irq, 1'b1);
         check_byte("irq_vector", irq_vector, IRQ_VECTOR_BASE + IRQ_VECTOR_STRIDE * idx);
         irq_ack = 1'b1;
         step();
         irq_ack = 1'b0;
         exp_if[idx] = 1'b0;
         check_bits("if_data", if_data, exp_if);
      end
      check_bit("irq", irq, 1'b0);
      check_byte("irq_vector", irq_vector, 8'h00);
      // Drop the leftover unenabled flag
      if_load = 1'b1;
      if_in = '0;
      step();
      if_load = 1'b0;
      check_bits("if_data", if_data, '0);
   endtask

   task automatic test_master_enable();
      if_set = 5'b00100;
      step();
      if_set = '0;
      check_bit("irq", irq, 1'b1);
      check_byte("irq_vector", irq_vector, 8'h50);
      ime_reset = 1'b1;
      step();
      ime_reset = 1'b0;
      check_bit("ime", ime, 1'b0);
      check_bit("irq", irq, 1'b0);
      check_bits("if_data", if_data, 5'b00100);
      // Set wins over reset
      ime_set = 1'b1;
      ime_reset = 1'b1;
      step();
      ime_set = 1'b0;
      ime_reset = 1'b0;
      check_bit("ime", ime, 1'b1);
      check_bit("irq", irq, 1'b1);
   endtask

   initial begin
      void'($urandom(32'h7da5_4a69));
      reset = 1'b1;
      addr = '0;
      wdata = '0;
      wr = 1'b0;
      rd = 1'b0;
      mem_disable = 1'b0;
      if_set = '0;
      if_in = '0;
      ie_in = '0;
      if_load = 1'b0;
      ie_load = 1'b0;
      irq_ack = 1'b0;
      ime_set = 1'b0;
      ime_reset = 1'b0;
      repeat (4) @(posedge clock);
      #2;
      reset = 1'b0;
      test_reset_state();
      test_high_ram();
      test_external();
      test_ie_register();
      test_priority();
      test_master_enable();
      if (UUT.u_chk.assert_failures == 0) begin
         $display(">>> PASS");
         $finish;
      end else begin
         $display("Bound assertions failed %0d times", UUT.u_chk.assert_failures);
         $display(">>> FAIL");
         $fatal(1, "Assertion failures");
      end
   end

endmodule

/* gb80_mem_irq.f */
hw/gb80_pkg.sv
hw/hram_port_if.sv
hw/high_ram.sv
hw/mem_decoder.sv
hw/interrupt_ctrl.sv
hw/gb80_mem_irq.sv
tests/gb80_mem_irq_chk.sv
tests/tb_gb80_mem_irq.sv
